/* common/ahb_pkg.sv */
//--------------------------------------------------------------------
// AHB-Lite definitions for the matrix decoder
//  Bus widths and the lowest decoded address bit
//  HTRANS and HRESP encodings
//  Response bundle of one output stage
//--------------------------------------------------------------------

package ahb_pkg;

    //----------------------------------------------------------------
    // Bus widths
    //----------------------------------------------------------------
    localparam int ADDR_W  = 32;       // HADDR width
    localparam int DEC_LSB = 10;       // 1 KB decode granule
    localparam int DATA_W  = 32;       // HRDATA width

    //----------------------------------------------------------------
    // Control encodings
    //----------------------------------------------------------------

    // Transfer type, bit 1 set for an active transfer
    typedef enum logic [1:0] {
        IDLE   = 2'b00,                // No transfer
        BUSY   = 2'b01,                // Master inserts a pause
        NONSEQ = 2'b10,                // First beat
        SEQ    = 2'b11                 // Following beat
    } htrans_t;

    // Slave response
    // Kept two bits wide to match the matrix port width
    typedef enum logic [1:0] {
        OKAY  = 2'b00,
        ERROR = 2'b01
    } hresp_t;

    //----------------------------------------------------------------
    // Data-phase response of one output stage
    //----------------------------------------------------------------
    typedef struct packed {
        logic              readyout;   // HREADYOUT
        hresp_t            resp;       // HRESP
        logic [DATA_W-1:0] rdata;      // HRDATA
    } stage_rsp_t;

endpackage

/* common/mtx_map_pkg.sv */
//--------------------------------------------------------------------
// Address map of one matrix input stage
//  Output stage count and port select encoding
//  Region entry and region table types
//  Default table of five regions, in 1 KB units
//--------------------------------------------------------------------

package mtx_map_pkg;

    //----------------------------------------------------------------
    // Output ports
    //----------------------------------------------------------------
    localparam int NUM_STAGES = 5;     // Output stages behind the decoder

    // Target of a transfer
    // 0 .. NUM_STAGES-1 name an output stage
    typedef logic [3:0] port_sel_t;

    localparam port_sel_t DFLT_PORT = 4'b1000;   // Built-in default slave

    //----------------------------------------------------------------
    // Region table
    //----------------------------------------------------------------

    // Decoded address field, HADDR[31:10]
    localparam int REG_W = ahb_pkg::ADDR_W - ahb_pkg::DEC_LSB;

    typedef struct packed {
        logic [REG_W-1:0] base;        // First KB of the region
        logic [REG_W-1:0] limit;       // Last KB, inclusive
    } region_t;

    // One entry per output stage, index is the port number
    typedef region_t region_map_t [NUM_STAGES];

    // Standard map
    //  0 : 0x2000_0000 - 0x2003_ffff
    //  1 : 0x0000_0000 - 0x000f_ffff
    //  2 : 0x4000_0000 - 0x4000_ffff
    //  3 : 0x4001_0000 - 0x4001_ffff
    //  4 : 0x4002_0000 - 0x4002_ffff
    localparam region_map_t DEFAULT_MAP = '{
        '{base: 22'h080000, limit: 22'h0800ff},   // SRAM
        '{base: 22'h000000, limit: 22'h0003ff},   // Code
        '{base: 22'h100000, limit: 22'h10003f},   // Peripheral block 0
        '{base: 22'h100040, limit: 22'h10007f},   // Peripheral block 1
        '{base: 22'h100080, limit: 22'h1000bf}    // Peripheral block 2
    };

endpackage

/* rtl/mtx_addr_decode.sv */
//--------------------------------------------------------------------
// Address-phase decode of one matrix input stage
//  Region compare against the map, IDLE hold on the data-phase port
//  Output stage and default slave selects, active flag selection
//--------------------------------------------------------------------

module mtx_addr_decode #(
    parameter mtx_map_pkg::region_map_t MAP = mtx_map_pkg::DEFAULT_MAP
) (
    input  logic                                      sel,          // HSEL from input stage
    input  logic [ahb_pkg::ADDR_W-1:ahb_pkg::DEC_LSB] decode_addr,  // HADDR[31:10]
    input  ahb_pkg::htrans_t                          trans,        // HTRANS
    input  mtx_map_pkg::port_sel_t                    data_port,    // Current data-phase target
    input  logic [mtx_map_pkg::NUM_STAGES-1:0]        stage_active, // Per-stage active flags
    output mtx_map_pkg::port_sel_t                    addr_port,    // Address-phase target
    output logic [mtx_map_pkg::NUM_STAGES-1:0]        stage_sel,    // Per-stage HSEL
    output logic                                      dflt_sel,     // Default slave HSEL
    output logic                                      active        // Chosen stage active flag
);

    localparam int NS = mtx_map_pkg::NUM_STAGES;

    logic [NS-1:0] region_hit;         // Address inside region i
    logic          idle_hold;          // Keep previous target

    //----------------------------------------------------------------
    // Region compare
    //----------------------------------------------------------------
    always_comb
    begin
        for (int i = 0; i < NS; i++)
        begin
            region_hit[i] = (decode_addr >= MAP[i].base) &&
                            (decode_addr <= MAP[i].limit);   // Inclusive limit
        end
    end

    // IDLE stays with the stage already in its data phase
    // A default slave target gives no hold, the address decides
    assign idle_hold = (trans == ahb_pkg::IDLE) && (data_port < NS);

    //----------------------------------------------------------------
    // Target port
    //----------------------------------------------------------------
    always_comb
    begin
        addr_port = mtx_map_pkg::DFLT_PORT;              // Unmapped
        if (idle_hold)
        begin
            addr_port = data_port;
        end
        else
        begin
            // Walk downwards so the lowest matching index wins
            for (int i = NS - 1; i >= 0; i--)
            begin
                if (region_hit[i])
                begin
                    addr_port = mtx_map_pkg::port_sel_t'(i);
                end
            end
        end
    end

    //----------------------------------------------------------------
    // Selects and active flag
    //----------------------------------------------------------------
    always_comb
    begin
        stage_sel = '0;
        active    = 1'b1;              // Default slave is always free
        for (int i = 0; i < NS; i++)
        begin
            if (addr_port == mtx_map_pkg::port_sel_t'(i))
            begin
                stage_sel[i] = sel;    // Qualified by HSEL
                active       = stage_active[i];
            end
        end
    end

    assign dflt_sel = sel && (addr_port == mtx_map_pkg::DFLT_PORT);

    // Regions of the map must not overlap
    a_region_onehot0 : assert property (@(decode_addr)
        $onehot0(region_hit))
        else $error("mtx_addr_decode: address inside more than one region");

endmodule

/* rtl/mtx_data_phase.sv */
//--------------------------------------------------------------------
// Data-phase side of the matrix decoder
//  Target register, loaded on each accepted address phase
//  Response mux for ready, response and read data
//--------------------------------------------------------------------

module mtx_data_phase (
    input  logic                                              HCLK,
    input  logic                                              HRESETn,
    input  logic                                              hready_in,  // Bus HREADY
    input  mtx_map_pkg::port_sel_t                            addr_port,  // Address-phase target
    input  ahb_pkg::stage_rsp_t [mtx_map_pkg::NUM_STAGES-1:0] stage_rsp,  // Stage responses
    input  logic                                              dflt_ready, // Default slave ready
    input  ahb_pkg::hresp_t                                   dflt_resp,  // Default slave resp
    output mtx_map_pkg::port_sel_t                            data_port,  // Data-phase target
    output ahb_pkg::stage_rsp_t                               rsp         // To input stage
);

    localparam int NS = mtx_map_pkg::NUM_STAGES;

    //----------------------------------------------------------------
    // Data-phase target
    //----------------------------------------------------------------

    // Loaded on bus HREADY and not on our own readyout
    // A buffered address may be accepted while our readyout is low
    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
        begin
            data_port <= '0;                             // Stage 0 after reset
        end
        else if (hready_in)
        begin
            data_port <= addr_port;
        end
    end

    //----------------------------------------------------------------
    // Response mux
    //----------------------------------------------------------------
    always_comb
    begin
        // Default slave unless a stage matches below
        rsp.readyout = dflt_ready;
        rsp.resp     = dflt_resp;
        rsp.rdata    = '0;                               // No read data
        for (int i = 0; i < NS; i++)
        begin
            if (data_port == mtx_map_pkg::port_sel_t'(i))
            begin
                rsp = stage_rsp[i];                      // Whole bundle
            end
        end
    end

    //----------------------------------------------------------------
    // Checks
    //----------------------------------------------------------------

    // Only a stage index or the default slave may reach the register
    a_data_port_valid : assert property (@(posedge HCLK) disable iff (!HRESETn)
        (data_port < NS) || (data_port == mtx_map_pkg::DFLT_PORT))
        else $error("mtx_data_phase: data_port holds an unmapped code");

endmodule

/* rtl/mtx_default_slave.sv */
//--------------------------------------------------------------------
// Default slave for unmapped addresses
//  Two-cycle ERROR for active transfers
//  Zero wait state OKAY for IDLE and BUSY
//--------------------------------------------------------------------

module mtx_default_slave (
    input  logic             HCLK,
    input  logic             HRESETn,
    input  logic             dflt_sel,    // Selected by the decode
    input  ahb_pkg::htrans_t trans,       // HTRANS
    input  logic             hready_in,   // Bus HREADY
    output logic             dflt_ready,  // HREADYOUT
    output ahb_pkg::hresp_t  dflt_resp    // HRESP
);

    // Response of the current data phase
    typedef struct packed {
        logic ready;                   // Readyout
        logic err;                     // ERROR response
    } dflt_state_t;

    dflt_state_t state;
    dflt_state_t state_nxt;
    logic        trans_req;            // Accepted NONSEQ or SEQ

    //----------------------------------------------------------------
    // Next state
    //----------------------------------------------------------------
    assign trans_req = dflt_sel && hready_in &&
                       ((trans == ahb_pkg::NONSEQ) || (trans == ahb_pkg::SEQ));

    // Wait cycle on a new request
    // Second ERROR cycle follows any wait cycle
    assign state_nxt.ready = ~trans_req;
    assign state_nxt.err   = trans_req | ~state.ready;

    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
        begin
            state <= '{ready: 1'b1, err: 1'b0};          // Idle, OKAY
        end
        else
        begin
            state <= state_nxt;
        end
    end

    assign dflt_ready = state.ready;
    assign dflt_resp  = state.err ? ahb_pkg::ERROR : ahb_pkg::OKAY;

    // ERROR always completes with a ready cycle
    a_err_two_cycle : assert property (@(posedge HCLK) disable iff (!HRESETn)
        !dflt_ready |=> dflt_ready && (dflt_resp == ahb_pkg::ERROR))
        else $error("mtx_default_slave: wait cycle not closed by ERROR");

endmodule

/* rtl/mtx_decoder.sv */
//--------------------------------------------------------------------
// Address decoder of one AHB-Lite matrix input stage
//  Address-phase decode, data-phase response routing
//  Built-in default slave for unmapped space
//--------------------------------------------------------------------

module mtx_decoder #(
    parameter mtx_map_pkg::region_map_t MAP = mtx_map_pkg::DEFAULT_MAP   // Region table
) (
    input  logic                                              HCLK,
    input  logic                                              HRESETn,

    // From the input stage
    input  logic                                              sel,          // HSEL
    input  logic [ahb_pkg::ADDR_W-1:ahb_pkg::DEC_LSB]         decode_addr,  // HADDR[31:10]
    input  ahb_pkg::htrans_t                                  trans,        // HTRANS
    input  logic                                              hready_in,    // Bus HREADY

    // Output stages
    input  logic [mtx_map_pkg::NUM_STAGES-1:0]                stage_active, // Active flags
    input  ahb_pkg::stage_rsp_t [mtx_map_pkg::NUM_STAGES-1:0] stage_rsp,    // Responses
    output logic [mtx_map_pkg::NUM_STAGES-1:0]                stage_sel,    // HSEL per stage

    // Back to the input stage
    output logic                                              active,       // Chosen active
    output ahb_pkg::stage_rsp_t                               rsp           // Routed response
);

    //----------------------------------------------------------------
    // Internal wiring
    //----------------------------------------------------------------
    mtx_map_pkg::port_sel_t addr_port;   // Address-phase target
    mtx_map_pkg::port_sel_t data_port;   // Data-phase target
    logic                   dflt_sel;    // Default slave HSEL
    logic                   dflt_ready;  // Default slave HREADYOUT
    ahb_pkg::hresp_t        dflt_resp;   // Default slave HRESP

    // Address phase
    mtx_addr_decode #(
        .MAP          (MAP)
    ) u_addr_decode (
        .sel          (sel),
        .decode_addr  (decode_addr),
        .trans        (trans),
        .data_port    (data_port),       // For the IDLE hold
        .stage_active (stage_active),
        .addr_port    (addr_port),
        .stage_sel    (stage_sel),
        .dflt_sel     (dflt_sel),
        .active       (active)
    );

    // Data phase
    mtx_data_phase u_data_phase (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .hready_in    (hready_in),
        .addr_port    (addr_port),
        .stage_rsp    (stage_rsp),
        .dflt_ready   (dflt_ready),
        .dflt_resp    (dflt_resp),
        .data_port    (data_port),
        .rsp          (rsp)
    );

    // Unmapped accesses land here
    mtx_default_slave u_default_slave (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .dflt_sel     (dflt_sel),
        .trans        (trans),
        .hready_in    (hready_in),
        .dflt_ready   (dflt_ready),
        .dflt_resp    (dflt_resp)
    );

endmodule

/* sim/mtx_decoder_model.svh */
//--------------------------------------------------------------------
// Reference model of the matrix decoder
//  Region lookup and data-phase target tracking
//  Default slave response state
//  Expected selects, active flag and routed response
//--------------------------------------------------------------------

`ifndef MTX_DECODER_MODEL_SVH
`define MTX_DECODER_MODEL_SVH

int   m_data_port  = 0;                // Target of the transfer in its data phase
logic m_dflt_ready = 1'b1;             // Default slave readyout
logic m_dflt_err   = 1'b0;             // Default slave ERROR flag

// First region holding the address, -1 when unmapped
function automatic int region_of(input logic [mtx_map_pkg::REG_W-1:0] a);
    int hit;
    hit = -1;
    for (int i = 0; i < mtx_map_pkg::NUM_STAGES; i++)
    begin
        if ((hit < 0) && (a >= mtx_map_pkg::DEFAULT_MAP[i].base) &&
            (a <= mtx_map_pkg::DEFAULT_MAP[i].limit))
        begin
            hit = i;
        end
    end
    return hit;
endfunction

// Address-phase target, IDLE keeps a stage already in its data phase
function automatic int target_of(input logic [mtx_map_pkg::REG_W-1:0] a,
                                 input ahb_pkg::htrans_t t);
    int hit;
    if ((t == ahb_pkg::IDLE) && (m_data_port < mtx_map_pkg::NUM_STAGES))
    begin
        return m_data_port;
    end
    hit = region_of(a);
    return (hit < 0) ? int'(mtx_map_pkg::DFLT_PORT) : hit;
endfunction

function automatic logic [mtx_map_pkg::NUM_STAGES-1:0] expected_sel(input logic s,
                                                                    input int tgt);
    logic [mtx_map_pkg::NUM_STAGES-1:0] v;
    v = '0;
    if (s && (tgt < mtx_map_pkg::NUM_STAGES))
    begin
        v[tgt] = 1'b1;
    end
    return v;
endfunction

// Default slave never stalls the address phase
function automatic logic expected_active(input int tgt,
                                         input logic [mtx_map_pkg::NUM_STAGES-1:0] act);
    return (tgt < mtx_map_pkg::NUM_STAGES) ? act[tgt] : 1'b1;
endfunction

function automatic ahb_pkg::stage_rsp_t expected_rsp(
    input ahb_pkg::stage_rsp_t [mtx_map_pkg::NUM_STAGES-1:0] rs);
    ahb_pkg::stage_rsp_t r;
    if (m_data_port < mtx_map_pkg::NUM_STAGES)
    begin
        return rs[m_data_port];
    end
    r.readyout = m_dflt_ready;
    r.resp     = m_dflt_err ? ahb_pkg::ERROR : ahb_pkg::OKAY;
    r.rdata    = '0;               // Default slave has no read data
    return r;
endfunction

// One rising HCLK edge with the inputs held during the cycle
task automatic model_step(input logic rst_n, input logic s,
                          input logic [mtx_map_pkg::REG_W-1:0] a,
                          input ahb_pkg::htrans_t t, input logic h);
    int   tgt;
    logic req;
    if (!rst_n)
    begin
        m_data_port  = 0;
        m_dflt_ready = 1'b1;
        m_dflt_err   = 1'b0;
    end
    else
    begin
        tgt = target_of(a, t);
        req = s && h && (tgt == int'(mtx_map_pkg::DFLT_PORT)) &&
              ((t == ahb_pkg::NONSEQ) || (t == ahb_pkg::SEQ));
        if (h)
        begin
            m_data_port = tgt;         // Address phase accepted
        end
        if (req)
        begin
            m_dflt_ready = 1'b0;       // First ERROR cycle, wait state
            m_dflt_err   = 1'b1;
        end
        else
        begin
            m_dflt_err   = !m_dflt_ready;   // Second ERROR cycle after a wait
            m_dflt_ready = 1'b1;
        end
    end
endtask

`endif

/* sim/tb_mtx_decoder.sv */
//--------------------------------------------------------------------
// Testbench for the matrix input stage decoder
//  Clock, reset and seeded random bus stimulus
//  Comparison against the reference model, watchdog and summary
//--------------------------------------------------------------------

module tb_mtx_decoder;

    localparam int NS          = mtx_map_pkg::NUM_STAGES;
    localparam int REG_W       = mtx_map_pkg::REG_W;
    localparam int RST_CYCLES  = 10;
    localparam int RESET_LEN   = 4;
    localparam int REGION_LEN  = 10;               // Per region
    localparam int UNMAP_LEN   = 60;
    localparam int IDLE_LEN    = 60;
    localparam int RANDOM_LEN  = 3000;
    localparam int TOTAL_LEN   = 1 + RST_CYCLES + RESET_LEN + NS * REGION_LEN +
                                 UNMAP_LEN + IDLE_LEN + RANDOM_LEN;
    localparam int WATCHDOG_T  = TOTAL_LEN * 40 * 3 / 2;   // Plus 50 percent

    logic                          HCLK;
    logic                          HRESETn;
    logic                          sel;
    logic [REG_W-1:0]              decode_addr;
    ahb_pkg::htrans_t              trans;
    logic                          hready_in;
    logic [NS-1:0]                 stage_active;
    ahb_pkg::stage_rsp_t [NS-1:0]  stage_rsp;
    logic [NS-1:0]                 stage_sel;
    logic                          active;
    ahb_pkg::stage_rsp_t           rsp;

    logic rst_level;                   // Reset level for the next cycle
    logic check_dflt_idle;             // Also check the default slave state
    int   error_count;
    int   start_errors;                // Errors before the current test
    int   tests_run;
    int   tests_failed;

    `include "mtx_decoder_model.svh"

    mtx_decoder #(
        .MAP          (mtx_map_pkg::DEFAULT_MAP)
    ) UUT (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .sel          (sel),
        .decode_addr  (decode_addr),
        .trans        (trans),
        .hready_in    (hready_in),
        .stage_active (stage_active),
        .stage_rsp    (stage_rsp),
        .stage_sel    (stage_sel),
        .active       (active),
        .rsp          (rsp)
    );

    always #20 HCLK = ~HCLK;           // 40 unit period

    //----------------------------------------------------------------
    // Stimulus helpers
    //----------------------------------------------------------------
    function automatic logic [REG_W-1:0] inside_region(input int r);
        logic [REG_W-1:0] span;
        span = mtx_map_pkg::DEFAULT_MAP[r].limit - mtx_map_pkg::DEFAULT_MAP[r].base + 1'b1;
        return mtx_map_pkg::DEFAULT_MAP[r].base + REG_W'($urandom % span);
    endfunction

    function automatic logic [REG_W-1:0] unmapped_addr();
        return {6'h3f, 16'($urandom)};   // Above every region
    endfunction

    // Biased toward region edges and unmapped space
    function automatic logic [REG_W-1:0] pick_addr();
        int k;
        k = $urandom % NS;
        case ($urandom % 10)
            0, 1, 2, 3 :
            begin
                case ($urandom % 4)
                    0       : return mtx_map_pkg::DEFAULT_MAP[k].base;
                    1       : return mtx_map_pkg::DEFAULT_MAP[k].limit;
                    2       : return REG_W'(mtx_map_pkg::DEFAULT_MAP[k].base - 1'b1);
                    default : return REG_W'(mtx_map_pkg::DEFAULT_MAP[k].limit + 1'b1);
                endcase
            end
            4, 5, 6 : return inside_region(k);
            7, 8    : return unmapped_addr();
            default : return REG_W'($urandom);
        endcase
    endfunction

    task automatic fill_stage_inputs();
        for (int i = 0; i < NS; i++)
        begin
            stage_rsp[i].readyout = $urandom % 2;
            stage_rsp[i].resp     = ($urandom % 2) ? ahb_pkg::ERROR : ahb_pkg::OKAY;
            stage_rsp[i].rdata    = $urandom;
        end
        stage_active = NS'($urandom);
    endtask

    //----------------------------------------------------------------
    // Checking
    //----------------------------------------------------------------
    task automatic report_value(input string name, input logic [63:0] exp_v,
                                input logic [63:0] act_v);
        $display("ERR time %0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
        error_count++;
    endtask

    task automatic check_outputs();
        int                  tgt;
        logic [NS-1:0]       exp_sel;
        logic                exp_act;
        ahb_pkg::stage_rsp_t exp_rsp;
        tgt     = target_of(decode_addr, trans);
        exp_sel = expected_sel(sel, tgt);
        exp_act = expected_active(tgt, stage_active);
        exp_rsp = expected_rsp(stage_rsp);
        assert (stage_sel === exp_sel) else report_value("stage_sel", exp_sel, stage_sel);
        assert (active === exp_act) else report_value("active", exp_act, active);
        assert (rsp.readyout === exp_rsp.readyout)
            else report_value("rsp.readyout", exp_rsp.readyout, rsp.readyout);
        assert (rsp.resp === exp_rsp.resp) else report_value("rsp.resp", exp_rsp.resp, rsp.resp);
        assert (rsp.rdata === exp_rsp.rdata)
            else report_value("rsp.rdata", exp_rsp.rdata, rsp.rdata);
        if (check_dflt_idle)
        begin
            assert (UUT.dflt_ready === 1'b1)
                else report_value("dflt_ready", 1'b1, UUT.dflt_ready);
            assert (UUT.dflt_resp === ahb_pkg::OKAY)
                else report_value("dflt_resp", ahb_pkg::OKAY, UUT.dflt_resp);
        end
    endtask

    // One bus cycle, entered just after a rising edge
    task automatic bus_cycle(input logic s, input logic [REG_W-1:0] a,
                             input ahb_pkg::htrans_t t);
        #2;
        HRESETn     = rst_level;
        sel         = s;
        decode_addr = a;
        trans       = t;
        fill_stage_inputs();
        if (m_data_port == int'(mtx_map_pkg::DFLT_PORT))
        begin
            hready_in = m_dflt_ready;      // Master waits on the default slave
        end
        else
        begin
            hready_in = (($urandom % 4) != 0);
        end
        @(negedge HCLK);
        if (HRESETn)
        begin
            check_outputs();
        end
        @(posedge HCLK);
        model_step(HRESETn, sel, decode_addr, trans, hready_in);
    endtask

    task automatic report_test(input string name, input int len);
        int errs;
        errs = error_count - start_errors;
        tests_run++;
        if (errs != 0)
        begin
            tests_failed++;
        end
        $display("Test %-10s %0d cycles, %0d errors: %s", name, len, errs,
                 (errs == 0) ? "ok" : "mismatch");
        start_errors = error_count;
    endtask

    //----------------------------------------------------------------
    // Test sequence
    //----------------------------------------------------------------
    initial
    begin
        HCLK = 1'b0;
        HRESETn = 1'b0;
        sel = 1'b0;
        decode_addr = '0;
        trans = ahb_pkg::IDLE;
        hready_in = 1'b1;
        stage_active = '0;
        stage_rsp = '0;
        rst_level = 1'b0;
        check_dflt_idle = 1'b0;
        error_count = 0;
        start_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        void'($urandom(32'h1385673c));

        @(posedge HCLK);
        repeat (RST_CYCLES) bus_cycle(1'b0, '0, ahb_pkg::IDLE);
        rst_level = 1'b1;

        check_dflt_idle = 1'b1;        // Stage 0 target, default slave idle
        repeat (RESET_LEN) bus_cycle(1'b0, pick_addr(), ahb_pkg::IDLE);
        check_dflt_idle = 1'b0;
        report_test("reset", RESET_LEN);

        for (int r = 0; r < NS; r++)
        begin
            repeat (REGION_LEN) bus_cycle(1'b1, inside_region(r), ahb_pkg::NONSEQ);
        end
        report_test("regions", NS * REGION_LEN);

        repeat (UNMAP_LEN)
            bus_cycle(1'b1, unmapped_addr(), ($urandom % 2) ? ahb_pkg::NONSEQ : ahb_pkg::IDLE);
        report_test("unmapped", UNMAP_LEN);

        for (int i = 0; i < IDLE_LEN; i++)
        begin
            if (i % 2 == 0)
                bus_cycle(1'b1, inside_region($urandom % NS), ahb_pkg::NONSEQ);
            else
                bus_cycle(1'b1, pick_addr(), ahb_pkg::IDLE);   // Target must hold
        end
        report_test("idle_hold", IDLE_LEN);

        repeat (RANDOM_LEN)
            bus_cycle(($urandom % 4) != 0, pick_addr(), ahb_pkg::htrans_t'($urandom % 4));
        report_test("random", RANDOM_LEN);

        $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
                 error_count);
        if (error_count == 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial
    begin
        #(WATCHDOG_T);
        $display("Timeout: the tests did not finish within %0d time units", WATCHDOG_T);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

/* sources.f */
+incdir+sim
common/ahb_pkg.sv
common/mtx_map_pkg.sv
rtl/mtx_addr_decode.sv
rtl/mtx_data_phase.sv
rtl/mtx_default_slave.sv
rtl/mtx_decoder.sv
sim/tb_mtx_decoder.sv

/* Bender.yml */
package:
  name: mtx_decoder

sources:
  - files:
      - common/ahb_pkg.sv
      - common/mtx_map_pkg.sv
      - rtl/mtx_addr_decode.sv
      - rtl/mtx_data_phase.sv
      - rtl/mtx_default_slave.sv
      - rtl/mtx_decoder.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_mtx_decoder.sv
